// File: bench/clk_rst_gen.sv
/*
 * Testbench clock and reset source
 *   10 ns clock
 *   Active-low reset held for 5 cycles
 */

`timescale 1ns/100ps
`default_nettype none

module clk_rst_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 5;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/uart_tb.sv
/*
 * Testbench of the memory-mapped serial port
 *   Stimulus table of bus accesses, status polls and line faults
 *   Loopback of tx into rx, or a bench-driven frame
 *   Immediate checks, error counts and cycle-limit timeout
 */

`timescale 1ns/100ps
`default_nettype none

module uart_tb;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_POLL, OP_INJECT} op_t;

    // Poll uses data as mask, inject uses data[8] as stop bit
    typedef struct packed {
        op_t             op;
        logic [3:0]      addr;
        logic [31:0]     data;
        logic [31:0]     exp_data;
        axil_pkg::resp_t exp_resp;
    } step_t;

    localparam logic [31:0] M_BUSY  = 32'h1 << axil_pkg::ST_TX_BUSY;
    localparam logic [31:0] M_VALID = 32'h1 << axil_pkg::ST_RX_VALID;
    localparam logic [31:0] M_OVR   = 32'h1 << axil_pkg::ST_OVERRUN;
    localparam logic [31:0] M_FERR  = 32'h1 << axil_pkg::ST_FRAME_ERR;

    logic            clk;
    logic            rst_n;
    logic [3:0]      awaddr;
    logic            awvalid;
    logic            awready;
    logic [31:0]     wdata;
    logic            wvalid;
    logic            wready;
    axil_pkg::resp_t bresp;
    logic            bvalid;
    logic            bready;
    logic [3:0]      araddr;
    logic            arvalid;
    logic            arready;
    logic [31:0]     rdata;
    axil_pkg::resp_t rresp;
    logic            rvalid;
    logic            rready;
    logic            tx;
    logic            rx_line;
    logic            inject_sel;
    logic            inject_line;

    step_t       steps[$];
    integer      seed;
    logic [31:0] rand_word;
    int          checks;
    int          mismatches;
    int          cycles;
    int          cycle_limit;

    clk_rst_gen i_clk_rst_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    // Loopback unless a frame is being injected
    assign rx_line = inject_sel ? inject_line : tx;

    uart_top i_uart_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .rx      (rx_line),
        .tx      (tx)
    );

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            mismatches++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic add_step(input op_t op, input logic [3:0] addr, input logic [31:0] data,
                            input logic [31:0] exp_data, input axil_pkg::resp_t exp_resp);
        steps.push_back({op, addr, data, exp_data, exp_resp});
    endtask

    // AW and W together, response taken while bvalid is high
    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                             output axil_pkg::resp_t resp);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(negedge clk); while (!awready);
        check_value("wready", 1'b1, wready);
        // Handshake on the next rising edge
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        resp = bresp;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
                            output axil_pkg::resp_t resp);
        araddr  = addr;
        arvalid = 1'b1;
        do @(negedge clk); while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
    endtask

    // Each status read also clears overrun and framing error
    task automatic poll_status(input logic [31:0] mask, input logic [31:0] want,
                               output axil_pkg::resp_t resp);
        logic [31:0] data;
        read_reg(axil_pkg::REG_STATUS, data, resp);
        while ((data & mask) != want) begin
            @(negedge clk);
            read_reg(axil_pkg::REG_STATUS, data, resp);
        end
    endtask

    // Start bit, data LSB first, chosen stop bit, then idle high
    task automatic inject_frame(input logic [7:0] data, input logic stop_bit);
        logic [9:0] frame;
        frame      = {stop_bit, data, 1'b0};
        inject_sel = 1'b1;
        for (int i = 0; i < uart_pkg::FRAME_BITS; i++) begin
            inject_line = frame[i];
            repeat (uart_pkg::BAUD_DIV) @(negedge clk);
        end
        inject_line = 1'b1;
        repeat (2 * uart_pkg::BAUD_DIV) @(negedge clk);
        inject_sel = 1'b0;
    endtask

    task automatic apply_step(input step_t s);
        logic [31:0]     data;
        axil_pkg::resp_t resp;
        case (s.op)
            OP_WRITE: begin
                write_reg(s.addr, s.data, resp);
                check_value("bresp", s.exp_resp, resp);
            end
            OP_READ: begin
                read_reg(s.addr, data, resp);
                check_value("rdata", s.exp_data, data);
                check_value("rresp", s.exp_resp, resp);
            end
            OP_POLL: begin
                poll_status(s.data, s.exp_data, resp);
                check_value("rresp", s.exp_resp, resp);
            end
            default: begin
                inject_frame(s.data[7:0], s.data[8]);
            end
        endcase
    endtask

    task automatic build_table();
        logic [7:0] bytes [4];
        bytes[0] = 8'h00;
        bytes[1] = 8'hFF;
        bytes[2] = 8'hA5;
        bytes[3] = rand_word[7:0];
        // Idle status after reset
        add_step(OP_READ, axil_pkg::REG_STATUS, 0, 0, axil_pkg::RESP_OKAY);
        // Loopback of single bytes
        for (int i = 0; i < 4; i++) begin
            add_step(OP_WRITE, axil_pkg::REG_TXDATA, bytes[i], 0, axil_pkg::RESP_OKAY);
            add_step(OP_POLL, axil_pkg::REG_STATUS, M_BUSY | M_VALID, M_VALID,
                     axil_pkg::RESP_OKAY);
            add_step(OP_READ, axil_pkg::REG_RXDATA, 0, bytes[i], axil_pkg::RESP_OKAY);
        end
        // Write while busy is refused, first byte comes back
        add_step(OP_WRITE, axil_pkg::REG_TXDATA, 8'h5A, 0, axil_pkg::RESP_OKAY);
        add_step(OP_WRITE, axil_pkg::REG_TXDATA, 8'hC3, 0, axil_pkg::RESP_SLVERR);
        add_step(OP_POLL, axil_pkg::REG_STATUS, M_BUSY | M_VALID, M_VALID,
                 axil_pkg::RESP_OKAY);
        add_step(OP_READ, axil_pkg::REG_RXDATA, 0, 8'h5A, axil_pkg::RESP_OKAY);
        // Overrun, older byte kept
        add_step(OP_WRITE, axil_pkg::REG_TXDATA, 8'h11, 0, axil_pkg::RESP_OKAY);
        add_step(OP_POLL, axil_pkg::REG_STATUS, M_BUSY | M_VALID, M_VALID,
                 axil_pkg::RESP_OKAY);
        add_step(OP_WRITE, axil_pkg::REG_TXDATA, 8'h22, 0, axil_pkg::RESP_OKAY);
        add_step(OP_POLL, axil_pkg::REG_STATUS, M_BUSY | M_VALID | M_OVR, M_VALID | M_OVR,
                 axil_pkg::RESP_OKAY);
        add_step(OP_READ, axil_pkg::REG_RXDATA, 0, 8'h11, axil_pkg::RESP_OKAY);
        add_step(OP_READ, axil_pkg::REG_STATUS, 0, 0, axil_pkg::RESP_OKAY);
        // Low stop bit on the line
        add_step(OP_INJECT, 0, {23'h0, 1'b0, 8'h3C}, 0, axil_pkg::RESP_OKAY);
        add_step(OP_READ, axil_pkg::REG_STATUS, 0, M_FERR, axil_pkg::RESP_OKAY);
        add_step(OP_READ, axil_pkg::REG_STATUS, 0, 0, axil_pkg::RESP_OKAY);
        // Error responses
        add_step(OP_READ, 4'hC, 0, 0, axil_pkg::RESP_SLVERR);
        add_step(OP_WRITE, axil_pkg::REG_STATUS, 32'h0F, 0, axil_pkg::RESP_SLVERR);
        add_step(OP_READ, axil_pkg::REG_TXDATA, 0, 0, axil_pkg::RESP_SLVERR);
        add_step(OP_READ, axil_pkg::REG_RXDATA, 0, 0, axil_pkg::RESP_SLVERR);
    endtask

    // Cycle limit from the table length
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("done: %0d checks, %0d mismatches, 1 timeouts", checks, mismatches);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wvalid      = 1'b0;
        bready      = 1'b1;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b1;
        inject_sel  = 1'b0;
        inject_line = 1'b1;
        checks      = 0;
        mismatches  = 0;
        cycles      = 0;
        seed        = 32'h918d_fe41;
        rand_word   = $random(seed);
        build_table();
        cycle_limit = steps.size() * 2 * uart_pkg::FRAME_BITS * uart_pkg::BAUD_DIV;
        @(posedge rst_n);
        @(negedge clk);
        check_value("tx", 1'b1, tx);
        // Bus handshakes idle after reset
        check_value("awready", 1'b0, awready);
        check_value("wready", 1'b0, wready);
        check_value("arready", 1'b0, arready);
        check_value("bvalid", 1'b0, bvalid);
        check_value("rvalid", 1'b0, rvalid);
        foreach (steps[i]) begin
            @(negedge clk);
            apply_step(steps[i]);
        end
        $display("done: %0d checks, %0d mismatches, 0 timeouts", checks, mismatches);
        if (mismatches == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
verilog/uart_pkg.sv
verilog/axil_pkg.sv
verilog/baud_gen.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_regs.sv
verilog/uart_top.sv
bench/clk_rst_gen.sv
bench/uart_tb.sv

// File: verilog/axil_pkg.sv
/*
 * AXI4-Lite register map of the serial port
 *   Address width and register offsets
 *   Status word bit positions, response codes
 */

`default_nettype none

package axil_pkg;

    localparam int ADDR_W = 4;

    // Register offsets
    localparam logic [ADDR_W-1:0] REG_TXDATA = 4'h0;  // write only
    localparam logic [ADDR_W-1:0] REG_RXDATA = 4'h4;  // read only
    localparam logic [ADDR_W-1:0] REG_STATUS = 4'h8;  // read only

    // Status word bits
    localparam int ST_TX_BUSY   = 0;
    localparam int ST_RX_VALID  = 1;
    localparam int ST_OVERRUN   = 2;
    localparam int ST_FRAME_ERR = 3;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_t;

endpackage

`default_nettype wire

// File: verilog/baud_gen.sv
/*
 * Bit-period generator
 *   Counter modulo BAUD_DIV, cleared while disabled
 *   Registered bit_end and mid_bit pulses
 */

`timescale 1ns/100ps
`default_nettype none

module baud_gen (
    input  logic clk,
    input  logic rst_n,
    input  logic enable,
    output logic bit_end,
    output logic mid_bit
);

    logic [$clog2(uart_pkg::BAUD_DIV)-1:0] cnt;

    // Count restarts from zero on every enable rise,
    // so the first bit_end lands BAUD_DIV cycles later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            bit_end <= 1'b0;
            mid_bit <= 1'b0;
        end else if (!enable) begin
            cnt     <= '0;
            bit_end <= 1'b0;
            mid_bit <= 1'b0;
        end else begin
            // Wrap at the last count
            if (cnt == uart_pkg::BAUD_DIV - 1) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            // Pulses registered, one cycle each per bit
            bit_end <= (cnt == uart_pkg::BAUD_DIV - 1);
            mid_bit <= (cnt == uart_pkg::BAUD_DIV / 2 - 1);
        end
    end

    // Half and full count never coincide
    // Mid-bit leads the bit end by half a bit
    a_pulse_excl: assert property (@(posedge clk) disable iff (!rst_n)
        bit_end |-> !mid_bit && $past(mid_bit, uart_pkg::BAUD_DIV / 2));

endmodule

`default_nettype wire

// File: verilog/uart_pkg.sv
/*
 * Serial line format constants and state encodings
 *   BAUD_DIV, DATA_BITS, FRAME_BITS
 *   Transmit and receive FSM state enums
 */

`default_nettype none

package uart_pkg;

    // Clock cycles per serial bit
    localparam int BAUD_DIV = 8;

    // 8N1 framing
    localparam int DATA_BITS = 8;
    // Start + data + stop
    localparam int FRAME_BITS = DATA_BITS + 2;

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_LOAD,
        TX_SHIFT,
        TX_WAIT
    } tx_state_t;

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

`default_nettype wire

// File: verilog/uart_regs.sv
/*
 * AXI4-Lite slave register block
 *   Write and read handshakes, address decode
 *   Transmit start with busy back-pressure
 *   Receive holding register, sticky overrun and framing error
 */

`timescale 1ns/100ps
`default_nettype none

module uart_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [axil_pkg::ADDR_W-1:0] awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [31:0]                 wdata,
    input  logic                        wvalid,
    output logic                        wready,
    output axil_pkg::resp_t             bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [axil_pkg::ADDR_W-1:0] araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [31:0]                 rdata,
    output axil_pkg::resp_t             rresp,
    output logic                        rvalid,
    input  logic                        rready,
    output logic                        tx_start,
    output logic [7:0]                  tx_byte,
    input  logic                        tx_busy,
    input  logic                        rx_done,
    input  logic                        rx_frame_err,
    input  logic [7:0]                  rx_byte
);

    logic            wr_hs;
    logic            rd_hs;
    logic            tx_active;
    logic            wr_ok;
    logic            rx_valid;
    logic            overrun;
    logic            frame_err;
    logic [7:0]      rx_hold;
    logic            rd_rx_clear;
    logic            rd_st_clear;
    logic [31:0]     status;
    logic [31:0]     rd_data;
    axil_pkg::resp_t rd_resp;

    // AW and W accepted together
    assign wr_hs = awvalid && awready;
    assign rd_hs = arvalid && arready;

    // Pending start counts as busy
    assign tx_active = tx_busy || tx_start;
    assign wr_ok     = (awaddr == axil_pkg::REG_TXDATA) && !tx_active;

    // Clear-on-read strobes
    assign rd_rx_clear = rd_hs && (araddr == axil_pkg::REG_RXDATA) && rx_valid;
    assign rd_st_clear = rd_hs && (araddr == axil_pkg::REG_STATUS);

    always_comb begin
        status                         = '0;
        status[axil_pkg::ST_TX_BUSY]   = tx_active;
        status[axil_pkg::ST_RX_VALID]  = rx_valid;
        status[axil_pkg::ST_OVERRUN]   = overrun;
        status[axil_pkg::ST_FRAME_ERR] = frame_err;
    end

    // Read decode, SLVERR with zero data by default
    always_comb begin
        rd_data = '0;
        rd_resp = axil_pkg::RESP_SLVERR;
        case (araddr)
            axil_pkg::REG_RXDATA: begin
                if (rx_valid) begin
                    rd_data[7:0] = rx_hold;
                    rd_resp      = axil_pkg::RESP_OKAY;
                end
            end
            axil_pkg::REG_STATUS: begin
                rd_data = status;
                rd_resp = axil_pkg::RESP_OKAY;
            end
            default: begin
                rd_resp = axil_pkg::RESP_SLVERR;
            end
        endcase
    end

    // Write channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= axil_pkg::RESP_OKAY;
            tx_start <= 1'b0;
        end else begin
            // Single-cycle ready, none while a response waits
            awready  <= !awready && awvalid && wvalid && !bvalid;
            wready   <= !awready && awvalid && wvalid && !bvalid;
            tx_start <= wr_hs && wr_ok;
            if (wr_hs) begin
                bvalid <= 1'b1;
                bresp  <= wr_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Only the low byte of wdata is used
    always_ff @(posedge clk) begin
        if (wr_hs && wr_ok) begin
            tx_byte <= wdata[7:0];
        end
    end

    // Read channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= !arready && arvalid && !rvalid;
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Data and response held until rready
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

    // Sticky flags, a new event wins over a clear in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_valid  <= 1'b0;
            overrun   <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            if (rx_done) begin
                rx_valid <= 1'b1;
            end else if (rd_rx_clear) begin
                rx_valid <= 1'b0;
            end
            if (rx_done && rx_valid && !rd_rx_clear) begin
                overrun <= 1'b1;
            end else if (rd_st_clear) begin
                overrun <= 1'b0;
            end
            if (rx_frame_err) begin
                frame_err <= 1'b1;
            end else if (rd_st_clear) begin
                frame_err <= 1'b0;
            end
        end
    end

    // On overrun the older byte is kept
    always_ff @(posedge clk) begin
        if (rx_done && (!rx_valid || rd_rx_clear)) begin
            rx_hold <= rx_byte;
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

`default_nettype wire

// File: verilog/uart_rx.sv
/*
 * 8N1 receiver
 *   Two-flop input synchronizer and start edge detect
 *   Start, data and stop FSM sampled on mid_bit
 *   Done and framing error pulses
 */

`timescale 1ns/100ps
`default_nettype none

module uart_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    input  logic       mid_bit,
    output logic       baud_en,
    output logic       rx_done,
    output logic       rx_frame_err,
    output logic [7:0] rx_byte
);

    uart_pkg::rx_state_t state;

    logic                                  rx_meta;
    logic                                  rx_s;
    logic                                  rx_q;
    logic [$clog2(uart_pkg::DATA_BITS)-1:0] bit_cnt;

    // Line idles high, so sync flops reset to one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
            rx_q    <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
            rx_q    <= rx_s;  // previous value for edge detect
        end
    end

    // Bit timing runs from the start edge to the stop sample
    assign baud_en = (state != uart_pkg::RX_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= uart_pkg::RX_IDLE;
            bit_cnt      <= '0;
            rx_done      <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            // One-cycle pulses
            rx_done      <= 1'b0;
            rx_frame_err <= 1'b0;
            case (state)
                uart_pkg::RX_IDLE: begin
                    if (rx_q && !rx_s) begin
                        state <= uart_pkg::RX_START;
                    end
                end
                // Glitch filter, start bit must still be low mid-bit
                uart_pkg::RX_START: begin
                    if (mid_bit) begin
                        if (!rx_s) begin
                            state   <= uart_pkg::RX_DATA;
                            bit_cnt <= '0;
                        end else begin
                            state <= uart_pkg::RX_IDLE;
                        end
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (mid_bit) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == uart_pkg::DATA_BITS - 1) begin
                            state <= uart_pkg::RX_STOP;
                        end
                    end
                end
                // Stop bit high means a good frame
                uart_pkg::RX_STOP: begin
                    if (mid_bit) begin
                        rx_done      <= rx_s;
                        rx_frame_err <= !rx_s;
                        state        <= uart_pkg::RX_IDLE;
                    end
                end
                default: begin
                    state <= uart_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // Data arrives LSB first
    always_ff @(posedge clk) begin
        if (state == uart_pkg::RX_DATA && mid_bit) begin
            rx_byte <= {rx_s, rx_byte[7:1]};
        end
    end

    // A frame ends either good or bad, never both
    // Bit timing already stopped when the result comes out
    a_done_excl: assert property (@(posedge clk) disable iff (!rst_n)
        (rx_done || rx_frame_err) |-> !(rx_done && rx_frame_err) && !baud_en);

endmodule

`default_nettype wire

// File: verilog/uart_top.sv
/*
 * Memory-mapped serial port top level
 *   AXI4-Lite register block, transmitter, receiver
 *   One baud generator per direction
 */

`timescale 1ns/100ps
`default_nettype none

module uart_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [axil_pkg::ADDR_W-1:0] awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [31:0]                 wdata,
    input  logic                        wvalid,
    output logic                        wready,
    output axil_pkg::resp_t             bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [axil_pkg::ADDR_W-1:0] araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [31:0]                 rdata,
    output axil_pkg::resp_t             rresp,
    output logic                        rvalid,
    input  logic                        rready,
    input  logic                        rx,
    output logic                        tx
);

    logic       tx_start;
    logic [7:0] tx_byte;
    logic       tx_busy;
    logic       tx_bit_end;
    logic       rx_baud_en;
    logic       rx_mid_bit;
    logic       rx_done;
    logic       rx_frame_err;
    logic [7:0] rx_byte;

    uart_regs i_uart_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .tx_start     (tx_start),
        .tx_byte      (tx_byte),
        .tx_busy      (tx_busy),
        .rx_done      (rx_done),
        .rx_frame_err (rx_frame_err),
        .rx_byte      (rx_byte)
    );

    // Transmit bit timing runs only while busy
    baud_gen tx_baud (
        .clk     (clk),
        .rst_n   (rst_n),
        .enable  (tx_busy),
        .bit_end (tx_bit_end),
        .mid_bit ()
    );

    uart_tx i_uart_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .bit_end  (tx_bit_end),
        .tx_byte  (tx_byte),
        .tx_busy  (tx_busy),
        .tx       (tx)
    );

    // Receiver samples at mid-bit only
    baud_gen rx_baud (
        .clk     (clk),
        .rst_n   (rst_n),
        .enable  (rx_baud_en),
        .bit_end (),
        .mid_bit (rx_mid_bit)
    );

    uart_rx i_uart_rx (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx           (rx),
        .mid_bit      (rx_mid_bit),
        .baud_en      (rx_baud_en),
        .rx_done      (rx_done),
        .rx_frame_err (rx_frame_err),
        .rx_byte      (rx_byte)
    );

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
/*
 * 8N1 transmitter
 *   Idle, load, shift and wait FSM
 *   Ten-bit shift buffer with start and stop bits
 *   Bit counter and registered serial output
 */

`timescale 1ns/100ps
`default_nettype none

module uart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_start,
    input  logic       bit_end,
    input  logic [7:0] tx_byte,
    output logic       tx_busy,
    output logic       tx
);

    uart_pkg::tx_state_t state;
    uart_pkg::tx_state_t state_nxt;

    logic [uart_pkg::DATA_BITS-1:0]  data_q;
    logic [uart_pkg::FRAME_BITS-1:0] shreg;
    logic [3:0]                      bit_cnt;
    logic                            shift_en;

    // Busy for the whole frame, also gates the baud generator
    assign tx_busy = (state != uart_pkg::TX_IDLE);

    // Shift only while a bit is on the line
    assign shift_en = bit_end &&
        (state == uart_pkg::TX_SHIFT || state == uart_pkg::TX_WAIT);

    always_comb begin
        state_nxt = state;
        case (state)
            uart_pkg::TX_IDLE: begin
                if (tx_start) begin
                    state_nxt = uart_pkg::TX_LOAD;
                end
            end
            uart_pkg::TX_LOAD: begin
                state_nxt = uart_pkg::TX_SHIFT;
            end
            // Start and data bits
            uart_pkg::TX_SHIFT: begin
                if (bit_end && bit_cnt == uart_pkg::DATA_BITS) begin
                    state_nxt = uart_pkg::TX_WAIT;
                end
            end
            // Stop bit on the line, frame ends with it
            uart_pkg::TX_WAIT: begin
                if (bit_end && bit_cnt == uart_pkg::FRAME_BITS - 1) begin
                    state_nxt = uart_pkg::TX_IDLE;
                end
            end
            default: begin
                state_nxt = uart_pkg::TX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= uart_pkg::TX_IDLE;
            bit_cnt <= '0;
            tx      <= 1'b1;
        end else begin
            state <= state_nxt;
            if (state == uart_pkg::TX_LOAD) begin
                bit_cnt <= '0;
                tx      <= 1'b0;  // start bit
            end else if (shift_en) begin
                bit_cnt <= bit_cnt + 1'b1;
                tx      <= shreg[1];
            end
        end
    end

    // Byte captured on the start request
    always_ff @(posedge clk) begin
        if (state == uart_pkg::TX_IDLE && tx_start) begin
            data_q <= tx_byte;
        end
    end

    // LSB first, ones shifted in behind the stop bit
    always_ff @(posedge clk) begin
        if (state == uart_pkg::TX_LOAD) begin
            shreg <= {1'b1, data_q, 1'b0};
        end else if (shift_en) begin
            shreg <= {1'b1, shreg[uart_pkg::FRAME_BITS-1:1]};
        end
    end

    // Register block must hold off while a frame runs
    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        tx_start |-> !tx_busy);

endmodule

`default_nettype wire
